// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_rv_core
RTL_TOP   ?= rv_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// expected response of one retired instruction
typedef struct packed {
  logic        wb_en;
  logic [4:0]  wb_idx;
  logic [63:0] wb_data;
  logic        mem_en;
  logic        mem_we;
  logic [63:0] addr;
  logic [63:0] wdata;
  logic [1:0]  size;
  logic        redir;
  logic [63:0] target;
  logic        invalid;
  logic        ebreak;
} expect_t;

// architectural state of the model
logic [63:0] m_regs [0:31];
logic [7:0]  m_mem [0:255];
logic [63:0] m_pc;

// integer ops selected by funct3 with alt picking sub and sra
function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                         input logic [63:0] a, input logic [63:0] b);
  logic [63:0] r;
  r = '0;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[5:0];
    3'd2: r = {63'b0, $signed(a) < $signed(b)};
    3'd3: r = {63'b0, a < b};
    3'd4: r = a ^ b;
    3'd5: begin
      if (alt) begin
        r = $signed(a) >>> b[5:0];
      end else begin
        r = a >> b[5:0];
      end
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// executes one instruction at m_pc and advances the model
function automatic expect_t model_step(input logic [31:0] inst);
  expect_t e;
  logic [6:0] opc;
  logic [6:0] f7;
  logic [2:0] f3;
  logic [4:0] rd;
  logic [63:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j, res;
  logic ok, wr;
  int nb;
  e     = '0;
  opc   = inst[6:0];
  f3    = inst[14:12];
  f7    = inst[31:25];
  rd    = inst[11:7];
  a     = m_regs[inst[19:15]];
  b     = m_regs[inst[24:20]];
  imm_i = {{52{inst[31]}}, inst[31:20]};
  imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  imm_u = {{32{inst[31]}}, inst[31:12], 12'h0};
  imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  ok    = 1'b1;
  wr    = 1'b0;
  res   = '0;
  nb    = 1 << f3[1:0];
  case (opc)
    7'h33: begin
      ok  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      wr  = 1'b1;
      res = alu_ref(f3, f7[5], a, b);
    end
    7'h13: begin
      if (f3 == 3'd1) begin
        ok = (inst[31:26] == 6'h00);
      end else if (f3 == 3'd5) begin
        ok = (inst[31:26] == 6'h00) || (inst[31:26] == 6'h10);
      end
      wr  = 1'b1;
      res = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
    end
    7'h03: begin
      ok       = (f3 != 3'd7);
      wr       = 1'b1;
      e.mem_en = 1'b1;
      e.addr   = a + imm_i;
      e.size   = f3[1:0];
      for (int k = 0; k < nb; k++) begin
        res[8*k +: 8] = m_mem[8'(e.addr + 64'(k))];
      end
      if (!f3[2] && nb < 8 && res[8*nb-1]) begin
        res = res | (~64'h0 << (8 * nb));
      end
    end
    7'h23: begin
      ok       = (f3 < 3'd4);
      e.mem_en = 1'b1;
      e.mem_we = 1'b1;
      e.addr   = a + imm_s;
      e.size   = f3[1:0];
      e.wdata  = b;
    end
    7'h63: begin
      ok = (f3 != 3'd2) && (f3 != 3'd3);
      case (f3)
        3'd0: e.redir = (a == b);
        3'd1: e.redir = (a != b);
        3'd4: e.redir = $signed(a) < $signed(b);
        3'd5: e.redir = $signed(a) >= $signed(b);
        3'd6: e.redir = (a < b);
        default: e.redir = (a >= b);
      endcase
      e.target = m_pc + imm_b;
    end
    7'h6f: begin
      wr       = 1'b1;
      res      = m_pc + 64'd4;
      e.redir  = 1'b1;
      e.target = m_pc + imm_j;
    end
    7'h67: begin
      ok       = (f3 == 3'd0);
      wr       = 1'b1;
      res      = m_pc + 64'd4;
      e.redir  = 1'b1;
      e.target = (a + imm_i) & ~64'h1;
    end
    7'h37: begin
      wr  = 1'b1;
      res = imm_u;
    end
    7'h17: begin
      wr  = 1'b1;
      res = m_pc + imm_u;
    end
    7'h73: begin
      ok       = (inst == 32'h00100073);
      e.ebreak = 1'b1;
    end
    default: ok = 1'b0;
  endcase
  if (!ok) begin
    e         = '0;
    e.invalid = 1'b1;
  end else begin
    e.wb_en   = wr && (rd != 5'd0);
    e.wb_idx  = rd;
    e.wb_data = res;
    if (e.wb_en) begin
      m_regs[rd] = res;
    end
    if (e.mem_we) begin
      for (int k = 0; k < nb; k++) begin
        m_mem[8'(e.addr + 64'(k))] = e.wdata[8*k +: 8];
      end
    end
  end
  m_pc = e.redir ? e.target : m_pc + 64'd4;
  return e;
endfunction

`endif

// File: dv/tb_rv_core.sv
module tb_rv_core
  import rv_pkg::*;
();

  localparam int prog_len = 200;
  localparam int timeout  = prog_len * 2 * 8 + 5 * 8 + 400;

  logic        clk_i;
  logic        arst_n_i;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic [63:0] pc_i;
  logic [63:0] mem_rdata_i;
  logic        retire_valid_o, wb_en_o, mem_en_o, mem_we_o;
  logic        redirect_o, invalid_o, ebreak_o;
  logic [63:0] retire_pc_o, wb_data_o, mem_addr_o, mem_wdata_o, redirect_pc_o;
  logic [4:0]  wb_idx_o;
  mem_size_e   mem_size_o;

  `include "tb_rv_model.svh"

  logic [31:0] prog [0:prog_len-1];
  logic [7:0]  dmem [0:255];
  logic [31:0] lfsr;
  logic [63:0] fetch_pc;
  logic        run, done, rst_stim;
  expect_t     exp_r;
  string       cur_test;
  int          errors, test_errs, retired;

  rv_core i_dut (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .inst_valid_i   (inst_valid_i),
    .inst_i         (inst_i),
    .pc_i           (pc_i),
    .mem_rdata_i    (mem_rdata_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .wb_en_o        (wb_en_o),
    .wb_idx_o       (wb_idx_o),
    .wb_data_o      (wb_data_o),
    .mem_en_o       (mem_en_o),
    .mem_we_o       (mem_we_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_size_o     (mem_size_o),
    .redirect_o     (redirect_o),
    .redirect_pc_o  (redirect_pc_o),
    .invalid_o      (invalid_o),
    .ebreak_o       (ebreak_o)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // short forward branches and jumps keep the program moving
  function automatic logic [31:0] gen_inst(input logic [63:0] pc);
    logic [3:0] kind;
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3;
    logic [31:0] x;
    logic [11:0] imm;
    logic [12:0] off;
    kind = 4'(rand_bits(4));
    rd   = 5'(rand_bits(3));
    rs1  = 5'(rand_bits(3));
    rs2  = 5'(rand_bits(3));
    f3   = 3'(rand_bits(3));
    x    = rand_bits(32);
    off  = 13'(8 + 4 * x[8:7]);
    case (kind)
      4'd3, 4'd4, 4'd5: begin
        if (f3 == 3'd1) begin
          imm = {6'h0, x[6:1]};
        end else if (f3 == 3'd5) begin
          imm = {1'b0, x[0], 4'h0, x[6:1]};
        end else begin
          imm = x[20:9];
        end
        return {imm, rs1, f3, rd, 7'h13};
      end
      4'd6: return {x[31:12], rd, 7'h37};
      4'd7: return {x[31:12], rd, 7'h17};
      4'd8: begin
        if (f3 == 3'd2 || f3 == 3'd3) begin
          f3 = 3'd0;
        end
        return b_type(off, rs2, rs1, f3);
      end
      4'd9: return j_type(21'(off), rd);
      4'd10: return {12'(pc + 64'(off)), 5'd0, 3'd0, rd, 7'h67};
      4'd11: return {4'h0, x[28:21], 5'd0, (f3 == 3'd7) ? 3'd3 : f3, rd, 7'h03};
      4'd12: return {3'h0, x[28:25], rs2, 5'd0, 1'b0, f3[1:0], x[24:21], x[30], 7'h23};
      4'd13: return x[0] ? {x[31:7], 7'h0b} : {x[20:9], 5'd0, 3'd7, rd, 7'h03};
      4'd14: return 32'h00100073;
      default: begin
        return {(x[0] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                rs2, rs1, f3, rd, 7'h33};
      end
    endcase
  endfunction

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] got);
    assert (exp === got) else begin
      $display("Fail %s %s expected %h actual %h", cur_test, what, exp, got);
      errors++;
      test_errs++;
    end
  endtask

  task automatic check_quiet();
    check_val("retire_valid_o", 64'd0, 64'(retire_valid_o));
    check_val("mem_en_o", 64'd0, 64'(mem_en_o));
    check_val("redirect_o", 64'd0, 64'(redirect_o));
    check_val("wb_en_o", 64'd0, 64'(wb_en_o));
  endtask

  // data memory answers in the same cycle
  always_comb begin
    for (int k = 0; k < 8; k++) begin
      mem_rdata_i[8*k +: 8] = dmem[8'(mem_addr_o[7:0] + 8'(k))];
    end
  end

  always @(negedge clk_i) begin
    if (mem_we_o) begin
      for (int k = 0; k < (1 << mem_size_o); k++) begin
        dmem[8'(mem_addr_o[7:0] + 8'(k))] <= mem_wdata_o[8*k +: 8];
      end
    end
  end

  // fetch follows redirect, or steps past the slot just presented
  always @(negedge clk_i) begin
    if (run) begin
      if (redirect_o) begin
        fetch_pc = redirect_pc_o;
      end else if (inst_valid_i) begin
        fetch_pc = fetch_pc + 64'd4;
      end
    end
  end

  always @(posedge clk_i) begin
    if (run && fetch_pc < 64'(prog_len * 4)) begin
      inst_valid_i <= 1'b1;
      inst_i       <= prog[int'(fetch_pc >> 2)];
      pc_i         <= fetch_pc;
    end else if (rst_stim) begin
      // jal and store alternate while reset must keep execute empty
      inst_valid_i <= 1'b1;
      inst_i       <= (inst_i == 32'h008000ef) ? 32'h00003023 : 32'h008000ef;
    end else begin
      inst_valid_i <= 1'b0;
      inst_i       <= '0;
    end
  end

  always @(negedge clk_i) begin
    if (run && !done && retire_valid_o) begin
      check_val("retire_pc_o", m_pc, retire_pc_o);
      exp_r = model_step(prog[int'(m_pc >> 2)]);
      retired++;
      check_val("redirect_o", 64'(exp_r.redir), 64'(redirect_o));
      if (exp_r.redir) begin
        check_val("redirect_pc_o", exp_r.target, redirect_pc_o);
      end
      check_val("wb_en_o", 64'(exp_r.wb_en), 64'(wb_en_o));
      if (exp_r.wb_en) begin
        check_val("wb_idx_o", 64'(exp_r.wb_idx), 64'(wb_idx_o));
        check_val("wb_data_o", exp_r.wb_data, wb_data_o);
      end
      check_val("mem_en_o", 64'(exp_r.mem_en), 64'(mem_en_o));
      if (exp_r.mem_en) begin
        check_val("mem_we_o", 64'(exp_r.mem_we), 64'(mem_we_o));
        check_val("mem_addr_o", exp_r.addr, mem_addr_o);
        check_val("mem_size_o", 64'(exp_r.size), 64'(mem_size_o));
        if (exp_r.mem_we) begin
          check_val("mem_wdata_o", exp_r.wdata, mem_wdata_o);
        end
      end
      check_val("invalid_o", 64'(exp_r.invalid), 64'(invalid_o));
      check_val("ebreak_o", 64'(exp_r.ebreak), 64'(ebreak_o));
      if (m_pc >= 64'(prog_len * 4)) begin
        done = 1'b1;
      end
    end
  end

  initial begin
    #(timeout);
    $display("watchdog: the program did not retire to its end in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    lfsr         = 32'd24;
    fetch_pc     = '0;
    m_pc         = '0;
    run          = 1'b0;
    done         = 1'b0;
    rst_stim     = 1'b1;
    errors       = 0;
    retired      = 0;
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    for (int a = 0; a < 256; a++) begin
      dmem[a]  = 8'(a * 37 + 11);
      m_mem[a] = 8'(a * 37 + 11);
    end
    for (int i = 0; i < prog_len; i++) begin
      prog[i] = gen_inst(64'(i * 4));
    end

    cur_test  = "reset";
    test_errs = 0;
    repeat (5) begin
      @(negedge clk_i);
      check_quiet();
    end
    rst_stim = 1'b0;
    @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_quiet();
    $display("test reset: %0d errors", test_errs);

    cur_test  = "program";
    test_errs = 0;
    run       = 1'b1;
    wait (done);
    $display("test program: %0d retired, %0d errors", retired, test_errs);
    $display("tests 2, retired %0d, errors %0d", retired, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: rtl/rv_core.sv
module rv_core
  import rv_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              inst_valid_i,
  input  logic [31:0]       inst_i,
  input  logic [xlen-1:0]   pc_i,
  input  logic [xlen-1:0]   mem_rdata_i,
  output logic              retire_valid_o,
  output logic [xlen-1:0]   retire_pc_o,
  output logic              wb_en_o,
  output logic [reg_aw-1:0] wb_idx_o,
  output logic [xlen-1:0]   wb_data_o,
  output logic              mem_en_o,
  output logic              mem_we_o,
  output logic [xlen-1:0]   mem_addr_o,
  output logic [xlen-1:0]   mem_wdata_o,
  output mem_size_e         mem_size_o,
  output logic              redirect_o,
  output logic [xlen-1:0]   redirect_pc_o,
  output logic              invalid_o,
  output logic              ebreak_o
);

  logic [reg_aw-1:0] rs1_idx, rs2_idx, rd_idx;
  logic [xlen-1:0]   rs1_data, rs2_data;
  logic [xlen-1:0]   dec_pc, op1, op2, op1_jp, op2_jp, st_data;
  logic              dec_valid, rd_wr_en, dec_invalid;
  logic [info_w-1:0] exu_info;

  rv_idu i_idu (
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .fwd_en_i     (wb_en_o),
    .fwd_idx_i    (wb_idx_o),
    .fwd_data_i   (wb_data_o),
    .flush_i      (redirect_o),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .dec_valid_o  (dec_valid),
    .pc_o         (dec_pc),
    .op1_o        (op1),
    .op2_o        (op2),
    .op1_jp_o     (op1_jp),
    .op2_jp_o     (op2_jp),
    .st_data_o    (st_data),
    .rd_wr_en_o   (rd_wr_en),
    .rd_idx_o     (rd_idx),
    .exu_info_o   (exu_info),
    .invalid_o    (dec_invalid)
  );

  // written back from execute at the next edge
  rv_regfile i_regfile (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .wr_en_i    (wb_en_o),
    .wr_idx_i   (wb_idx_o),
    .wr_data_i  (wb_data_o),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_exu i_exu (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .dec_valid_i    (dec_valid),
    .dec_pc_i       (dec_pc),
    .dec_op1_i      (op1),
    .dec_op2_i      (op2),
    .dec_op1_jp_i   (op1_jp),
    .dec_op2_jp_i   (op2_jp),
    .dec_st_data_i  (st_data),
    .dec_rd_wr_en_i (rd_wr_en),
    .dec_rd_idx_i   (rd_idx),
    .dec_info_i     (exu_info),
    .dec_invalid_i  (dec_invalid),
    .mem_rdata_i    (mem_rdata_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .wb_en_o        (wb_en_o),
    .wb_idx_o       (wb_idx_o),
    .wb_data_o      (wb_data_o),
    .mem_en_o       (mem_en_o),
    .mem_we_o       (mem_we_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_size_o     (mem_size_o),
    .redirect_o     (redirect_o),
    .redirect_pc_o  (redirect_pc_o),
    .invalid_o      (invalid_o),
    .ebreak_o       (ebreak_o)
  );

endmodule

// File: rtl/rv_exu.sv
module rv_exu
  import rv_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              dec_valid_i,
  input  logic [xlen-1:0]   dec_pc_i,
  input  logic [xlen-1:0]   dec_op1_i,
  input  logic [xlen-1:0]   dec_op2_i,
  input  logic [xlen-1:0]   dec_op1_jp_i,
  input  logic [xlen-1:0]   dec_op2_jp_i,
  input  logic [xlen-1:0]   dec_st_data_i,
  input  logic              dec_rd_wr_en_i,
  input  logic [reg_aw-1:0] dec_rd_idx_i,
  input  logic [info_w-1:0] dec_info_i,
  input  logic              dec_invalid_i,
  input  logic [xlen-1:0]   mem_rdata_i,
  output logic              retire_valid_o,
  output logic [xlen-1:0]   retire_pc_o,
  output logic              wb_en_o,
  output logic [reg_aw-1:0] wb_idx_o,
  output logic [xlen-1:0]   wb_data_o,
  output logic              mem_en_o,
  output logic              mem_we_o,
  output logic [xlen-1:0]   mem_addr_o,
  output logic [xlen-1:0]   mem_wdata_o,
  output mem_size_e         mem_size_o,
  output logic              redirect_o,
  output logic [xlen-1:0]   redirect_pc_o,
  output logic              invalid_o,
  output logic              ebreak_o
);

  logic              ex_valid, ex_rd_wr_en, ex_invalid;
  logic [xlen-1:0]   ex_pc, ex_op1, ex_op2, ex_op1_jp, ex_op2_jp, ex_st_data;
  logic [reg_aw-1:0] ex_rd_idx;
  logic [info_w-1:0] ex_info;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid    <= 1'b0;
      ex_rd_wr_en <= 1'b0;
      ex_invalid  <= 1'b0;
      ex_pc       <= '0;
      ex_op1      <= '0;
      ex_op2      <= '0;
      ex_op1_jp   <= '0;
      ex_op2_jp   <= '0;
      ex_st_data  <= '0;
      ex_rd_idx   <= '0;
      ex_info     <= '0;
    end else begin
      ex_valid    <= dec_valid_i;
      ex_rd_wr_en <= dec_rd_wr_en_i;
      ex_invalid  <= dec_invalid_i;
      ex_pc       <= dec_pc_i;
      ex_op1      <= dec_op1_i;
      ex_op2      <= dec_op2_i;
      ex_op1_jp   <= dec_op1_jp_i;
      ex_op2_jp   <= dec_op2_jp_i;
      ex_st_data  <= dec_st_data_i;
      ex_rd_idx   <= dec_rd_idx_i;
      ex_info     <= dec_info_i;
    end
  end

  exu_class_e cls;
  logic is_alu, is_bjp, is_ls;
  assign cls    = exu_class_e'(ex_info[2:0]);
  assign is_alu = (cls == cls_alu);
  assign is_bjp = (cls == cls_bjp);
  assign is_ls  = (cls == cls_ls);

  // shared by add, link value and memory address
  logic [xlen-1:0] sum, alu_res;
  logic [5:0] shamt;
  assign sum   = ex_op1 + ex_op2;
  assign shamt = ex_op2[5:0];

  assign alu_res =
    ({xlen{ex_info[alu_add]}}  & sum) |
    ({xlen{ex_info[alu_sub]}}  & (ex_op1 - ex_op2)) |
    ({xlen{ex_info[alu_sll]}}  & (ex_op1 << shamt)) |
    ({xlen{ex_info[alu_slt]}}  & xlen'($signed(ex_op1) < $signed(ex_op2))) |
    ({xlen{ex_info[alu_sltu]}} & xlen'(ex_op1 < ex_op2)) |
    ({xlen{ex_info[alu_xor]}}  & (ex_op1 ^ ex_op2)) |
    ({xlen{ex_info[alu_srl]}}  & (ex_op1 >> shamt)) |
    ({xlen{ex_info[alu_sra]}}  & xlen'($signed(ex_op1) >>> shamt)) |
    ({xlen{ex_info[alu_or]}}   & (ex_op1 | ex_op2)) |
    ({xlen{ex_info[alu_and]}}  & (ex_op1 & ex_op2)) |
    ({xlen{ex_info[alu_lui]}}  & ex_op2);

  // branch compare on rs1 and rs2
  logic eq, lt, ltu, taken;
  logic [xlen-1:0] target;
  assign eq  = (ex_op1 == ex_op2);
  assign lt  = $signed(ex_op1) < $signed(ex_op2);
  assign ltu = ex_op1 < ex_op2;

  assign taken = is_bjp & (ex_info[bjp_jal] | ex_info[bjp_jalr] |
                           (ex_info[bjp_beq] & eq) | (ex_info[bjp_bne] & ~eq) |
                           (ex_info[bjp_blt] & lt) | (ex_info[bjp_bge] & ~lt) |
                           (ex_info[bjp_bltu] & ltu) | (ex_info[bjp_bgeu] & ~ltu));

  assign target        = ex_op1_jp + ex_op2_jp;
  assign redirect_o    = ex_valid & taken;
  assign redirect_pc_o = {target[xlen-1:1], target[0] & ~ex_info[bjp_jalr]};

  mem_size_e ls_size;
  logic [xlen-1:0] ld_data;
  logic usign;
  assign usign = ex_info[ls_usign];

  always_comb begin
    if (ex_info[ls_dbl]) begin
      ls_size = sz_d;
    end else if (ex_info[ls_word]) begin
      ls_size = sz_w;
    end else if (ex_info[ls_half]) begin
      ls_size = sz_h;
    end else begin
      ls_size = sz_b;
    end
  end

  // read data arrives right aligned
  always_comb begin
    case (ls_size)
      sz_b:    ld_data = {{(xlen-8){~usign & mem_rdata_i[7]}}, mem_rdata_i[7:0]};
      sz_h:    ld_data = {{(xlen-16){~usign & mem_rdata_i[15]}}, mem_rdata_i[15:0]};
      sz_w:    ld_data = {{(xlen-32){~usign & mem_rdata_i[31]}}, mem_rdata_i[31:0]};
      default: ld_data = mem_rdata_i;
    endcase
  end

  assign mem_en_o    = ex_valid & is_ls;
  assign mem_we_o    = mem_en_o & ex_info[ls_store];
  assign mem_addr_o  = sum;
  assign mem_wdata_o = ex_st_data;
  assign mem_size_o  = ls_size;

  assign wb_en_o   = ex_valid & ex_rd_wr_en;
  assign wb_idx_o  = ex_rd_idx;
  assign wb_data_o = is_ls ? ld_data : (is_bjp ? sum : alu_res);

  assign retire_valid_o = ex_valid;
  assign retire_pc_o    = ex_pc;
  assign invalid_o      = ex_valid & ex_invalid;
  assign ebreak_o       = ex_valid & is_alu & ex_info[alu_ebreak];

endmodule

// File: rtl/rv_idu.sv
module rv_idu
  import rv_pkg::*;
(
  input  logic              inst_valid_i,
  input  logic [31:0]       inst_i,
  input  logic [xlen-1:0]   pc_i,
  input  logic [xlen-1:0]   rs1_data_i,
  input  logic [xlen-1:0]   rs2_data_i,
  input  logic              fwd_en_i,
  input  logic [reg_aw-1:0] fwd_idx_i,
  input  logic [xlen-1:0]   fwd_data_i,
  input  logic              flush_i,
  output logic [reg_aw-1:0] rs1_idx_o,
  output logic [reg_aw-1:0] rs2_idx_o,
  output logic              dec_valid_o,
  output logic [xlen-1:0]   pc_o,
  output logic [xlen-1:0]   op1_o,
  output logic [xlen-1:0]   op2_o,
  output logic [xlen-1:0]   op1_jp_o,
  output logic [xlen-1:0]   op2_jp_o,
  output logic [xlen-1:0]   st_data_o,
  output logic              rd_wr_en_o,
  output logic [reg_aw-1:0] rd_idx_o,
  output logic [info_w-1:0] exu_info_o,
  output logic              invalid_o
);

  opcode_e opc;
  logic [4:0] rd, rs1, rs2;
  logic [6:0] funct7;
  logic [7:0] f3;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  logic [xlen-1:0] rs1_val, rs2_val;
  logic [info_w-1:0] alu_info, bjp_info, ls_info;

  assign opc    = opcode_e'(inst_i[6:0]);
  assign rd     = inst_i[11:7];
  assign rs1    = inst_i[19:15];
  assign rs2    = inst_i[24:20];
  assign funct7 = inst_i[31:25];
  // one-hot funct3
  assign f3     = 8'b1 << inst_i[14:12];

  logic is_op, is_imm, is_load, is_store, is_branch;
  assign is_op     = (opc == opc_op);
  assign is_imm    = (opc == opc_op_imm);
  assign is_load   = (opc == opc_load);
  assign is_store  = (opc == opc_store);
  assign is_branch = (opc == opc_branch);

  logic f7_0, f7_20, f6_0, f6_10;
  assign f7_0  = (funct7 == 7'h00);
  assign f7_20 = (funct7 == 7'h20);
  // rv64 immediate shifts carry a 6-bit shamt
  assign f6_0  = (inst_i[31:26] == 6'h00);
  assign f6_10 = (inst_i[31:26] == 6'h10);

  // register forms
  logic add, sub, sll, slt, sltu, xor_, srl, sra, or_, and_;
  assign add  = is_op & f3[0] & f7_0;
  assign sub  = is_op & f3[0] & f7_20;
  assign sll  = is_op & f3[1] & f7_0;
  assign slt  = is_op & f3[2] & f7_0;
  assign sltu = is_op & f3[3] & f7_0;
  assign xor_ = is_op & f3[4] & f7_0;
  assign srl  = is_op & f3[5] & f7_0;
  assign sra  = is_op & f3[5] & f7_20;
  assign or_  = is_op & f3[6] & f7_0;
  assign and_ = is_op & f3[7] & f7_0;

  // immediate forms
  logic addi, slli, slti, sltiu, xori, srli, srai, ori, andi;
  assign addi  = is_imm & f3[0];
  assign slli  = is_imm & f3[1] & f6_0;
  assign slti  = is_imm & f3[2];
  assign sltiu = is_imm & f3[3];
  assign xori  = is_imm & f3[4];
  assign srli  = is_imm & f3[5] & f6_0;
  assign srai  = is_imm & f3[5] & f6_10;
  assign ori   = is_imm & f3[6];
  assign andi  = is_imm & f3[7];

  logic lb, lh, lw, ld, lbu, lhu, lwu, sb, sh, sw, sd;
  assign lb  = is_load & f3[0];
  assign lh  = is_load & f3[1];
  assign lw  = is_load & f3[2];
  assign ld  = is_load & f3[3];
  assign lbu = is_load & f3[4];
  assign lhu = is_load & f3[5];
  assign lwu = is_load & f3[6];
  assign sb  = is_store & f3[0];
  assign sh  = is_store & f3[1];
  assign sw  = is_store & f3[2];
  assign sd  = is_store & f3[3];

  logic beq, bne, blt, bge, bltu, bgeu, jal, jalr, lui, auipc, ebreak;
  assign beq    = is_branch & f3[0];
  assign bne    = is_branch & f3[1];
  assign blt    = is_branch & f3[4];
  assign bge    = is_branch & f3[5];
  assign bltu   = is_branch & f3[6];
  assign bgeu   = is_branch & f3[7];
  assign jal    = (opc == opc_jal);
  assign jalr   = (opc == opc_jalr) & f3[0];
  assign lui    = (opc == opc_lui);
  assign auipc  = (opc == opc_auipc);
  assign ebreak = (opc == opc_system) & (inst_i[31:7] == {12'h001, 13'h0});

  logic alu_r, alu_i, ld_any, st_any, br_any, known;
  assign alu_r  = add | sub | sll | slt | sltu | xor_ | srl | sra | or_ | and_;
  assign alu_i  = addi | slli | slti | sltiu | xori | srli | srai | ori | andi;
  assign ld_any = lb | lh | lw | ld | lbu | lhu | lwu;
  assign st_any = sb | sh | sw | sd;
  assign br_any = beq | bne | blt | bge | bltu | bgeu;
  assign known  = alu_r | alu_i | ld_any | st_any | br_any | jal | jalr | lui | auipc | ebreak;

  assign imm_i = {{(xlen-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{(xlen-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{(xlen-13){inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};
  assign imm_u = {{(xlen-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{(xlen-21){inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};

  assign imm = ({xlen{alu_i | ld_any | jalr}} & imm_i) |
               ({xlen{st_any}}               & imm_s) |
               ({xlen{br_any}}               & imm_b) |
               ({xlen{jal}}                  & imm_j) |
               ({xlen{lui | auipc}}          & imm_u);

  // bypass from the instruction in execute
  assign rs1_val = (fwd_en_i && fwd_idx_i == rs1) ? fwd_data_i : rs1_data_i;
  assign rs2_val = (fwd_en_i && fwd_idx_i == rs2) ? fwd_data_i : rs2_data_i;

  assign op1_o = ({xlen{alu_r | alu_i | ld_any | st_any | br_any}} & rs1_val) |
                 ({xlen{auipc | jal | jalr}}                        & pc_i);

  // jumps add 4 to pc for the link value
  assign op2_o = ({xlen{alu_r | br_any}}                     & rs2_val) |
                 ({xlen{alu_i | ld_any | st_any | auipc | lui}} & imm) |
                 ({xlen{jal | jalr}}                          & xlen'(4));

  assign op1_jp_o = ({xlen{br_any | jal}} & pc_i) | ({xlen{jalr}} & rs1_val);
  assign op2_jp_o = {xlen{br_any | jal | jalr}} & imm;
  assign st_data_o = rs2_val;

  assign rs1_idx_o   = rs1;
  assign rs2_idx_o   = rs2;
  assign rd_idx_o    = rd;
  assign pc_o        = pc_i;
  assign invalid_o   = ~known;
  assign dec_valid_o = inst_valid_i & ~flush_i;
  assign rd_wr_en_o  = known & (rd != '0) & ~(st_any | br_any | ebreak);

  always_comb begin
    alu_info             = '0;
    alu_info[2:0]        = cls_alu;
    alu_info[alu_add]    = add | addi | auipc;
    alu_info[alu_sub]    = sub;
    alu_info[alu_sll]    = sll | slli;
    alu_info[alu_slt]    = slt | slti;
    alu_info[alu_sltu]   = sltu | sltiu;
    alu_info[alu_xor]    = xor_ | xori;
    alu_info[alu_srl]    = srl | srli;
    alu_info[alu_sra]    = sra | srai;
    alu_info[alu_or]     = or_ | ori;
    alu_info[alu_and]    = and_ | andi;
    alu_info[alu_lui]    = lui;
    alu_info[alu_ebreak] = ebreak;

    bjp_info           = '0;
    bjp_info[2:0]      = cls_bjp;
    bjp_info[bjp_jal]  = jal;
    bjp_info[bjp_jalr] = jalr;
    bjp_info[bjp_beq]  = beq;
    bjp_info[bjp_bne]  = bne;
    bjp_info[bjp_blt]  = blt;
    bjp_info[bjp_bge]  = bge;
    bjp_info[bjp_bltu] = bltu;
    bjp_info[bjp_bgeu] = bgeu;

    ls_info           = '0;
    ls_info[2:0]      = cls_ls;
    ls_info[ls_load]  = ld_any;
    ls_info[ls_store] = st_any;
    ls_info[ls_usign] = lbu | lhu | lwu;
    ls_info[ls_byte]  = lb | lbu | sb;
    ls_info[ls_half]  = lh | lhu | sh;
    ls_info[ls_word]  = lw | lwu | sw;
    ls_info[ls_dbl]   = ld | sd;
  end

  always_comb begin
    if (alu_r | alu_i | lui | auipc | ebreak) begin
      exu_info_o = alu_info;
    end else if (br_any | jal | jalr) begin
      exu_info_o = bjp_info;
    end else if (ld_any | st_any) begin
      exu_info_o = ls_info;
    end else begin
      exu_info_o = info_w'(cls_none);
    end
  end

endmodule

// File: rtl/rv_pkg.sv
package rv_pkg;

  // architectural widths
  localparam int xlen   = 64;
  localparam int nreg   = 32;
  localparam int reg_aw = 5;
  localparam int info_w = 15;

  // major opcodes of the base integer set
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_system = 7'b1110011
  } opcode_e;

  // execute class in bits 2:0 of the info word
  typedef enum logic [2:0] {
    cls_none = 3'd0,
    cls_alu  = 3'd1,
    cls_bjp  = 3'd2,
    cls_ls   = 3'd3
  } exu_class_e;

  // alu one-hot positions
  localparam int alu_add    = 3;
  localparam int alu_sub    = 4;
  localparam int alu_sll    = 5;
  localparam int alu_slt    = 6;
  localparam int alu_sltu   = 7;
  localparam int alu_xor    = 8;
  localparam int alu_srl    = 9;
  localparam int alu_sra    = 10;
  localparam int alu_or     = 11;
  localparam int alu_and    = 12;
  localparam int alu_lui    = 13;
  localparam int alu_ebreak = 14;

  // branch and jump positions
  localparam int bjp_jal  = 3;
  localparam int bjp_jalr = 4;
  localparam int bjp_beq  = 5;
  localparam int bjp_bne  = 6;
  localparam int bjp_blt  = 7;
  localparam int bjp_bge  = 8;
  localparam int bjp_bltu = 9;
  localparam int bjp_bgeu = 10;

  // load/store positions
  localparam int ls_load  = 3;
  localparam int ls_store = 4;
  localparam int ls_usign = 5;
  localparam int ls_byte  = 6;
  localparam int ls_half  = 7;
  localparam int ls_word  = 8;
  localparam int ls_dbl   = 9;

  typedef enum logic [1:0] {
    sz_b = 2'd0,
    sz_h = 2'd1,
    sz_w = 2'd2,
    sz_d = 2'd3
  } mem_size_e;

endpackage

// File: rtl/rv_regfile.sv
module rv_regfile
  import rv_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic [reg_aw-1:0] rs1_idx_i,
  input  logic [reg_aw-1:0] rs2_idx_i,
  input  logic              wr_en_i,
  input  logic [reg_aw-1:0] wr_idx_i,
  input  logic [xlen-1:0]   wr_data_i,
  output logic [xlen-1:0]   rs1_data_o,
  output logic [xlen-1:0]   rs2_data_o
);

  // x0 has no storage
  logic [xlen-1:0] regs [1:nreg-1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < nreg; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_idx_i != '0)) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

// File: sim.f
+incdir+dv
rtl/rv_pkg.sv
rtl/rv_regfile.sv
rtl/rv_idu.sv
rtl/rv_exu.sv
rtl/rv_core.sv
dv/tb_rv_core.sv
